// File: common/fp_pkg.sv
////////////////////////////////////////////////////////////////////////////
// single precision only and no subnormal encodings are produced
// rounding codes 5 to 7 fall back to round to nearest even
////////////////////////////////////////////////////////////////////////////
package fp_pkg;

   // packed single-precision word
   typedef logic [31:0] fp32_t;

   // biased exponent field
   typedef logic [7:0] exp_t;

   // significand with the hidden bit in front
   typedef logic [23:0] mant_t;

   // aligned significand with guard round and sticky at the bottom
   typedef logic [26:0] ext_frac_t;

   // stage-2 sum with one carry bit on top
   typedef logic [27:0] sum_t;

   // alignment shift or leading-zero count
   typedef logic [4:0] shamt_t;

   // RISC-V frm encoding
   typedef logic [2:0] rm_t;

   // rounding modes
   localparam rm_t RM_RNE = 3'd0;
   localparam rm_t RM_RTZ = 3'd1;
   localparam rm_t RM_RDN = 3'd2;
   localparam rm_t RM_RUP = 3'd3;
   localparam rm_t RM_RMM = 3'd4;

   // canonical quiet NaN
   localparam fp32_t QNAN = 32'h7fc0_0000;

   // infinities
   localparam fp32_t POS_INF = 32'h7f80_0000;
   localparam fp32_t NEG_INF = 32'hff80_0000;

   // largest finite magnitude with a clear sign bit
   localparam fp32_t MAX_FINITE = 32'h7f7f_ffff;

endpackage

// File: design/fp_align.sv
`timescale 1ns/1ns
////////////////////////////////////////////////////////////////////////////
// subnormal operands are read as zero of the same sign
////////////////////////////////////////////////////////////////////////////
module fp_align import fp_pkg::*; (
   input  logic      clk,
   input  logic      rst,
   input  fp32_t     a,
   input  fp32_t     b,
   input  logic      sub,
   output logic      s1_sign,
   output logic      s1_eff_sub,
   output exp_t      s1_exp,
   output ext_frac_t s1_big,
   output ext_frac_t s1_small
);

   logic        b_sign;
   exp_t        a_exp;
   exp_t        b_exp;
   mant_t       a_mant;
   mant_t       b_mant;
   logic        a_ge_b;
   exp_t        big_exp;
   exp_t        small_exp;
   mant_t       big_mant;
   mant_t       small_mant;
   exp_t        exp_diff;
   shamt_t      shift;
   logic [53:0] shifted_wide;
   logic        sticky;

   // subtraction is an add with b negated
   assign b_sign = b[31] ^ sub;
   assign a_exp  = a[30:23];
   assign b_exp  = b[30:23];

   // zero exponent drops the fraction so subnormals become zero
   assign a_mant = (a_exp == '0) ? '0 : {1'b1, a[22:0]};
   assign b_mant = (b_exp == '0) ? '0 : {1'b1, b[22:0]};

   // order by magnitude
   assign a_ge_b     = {a_exp, a_mant} >= {b_exp, b_mant};
   assign big_exp    = a_ge_b ? a_exp : b_exp;
   assign small_exp  = a_ge_b ? b_exp : a_exp;
   assign big_mant   = a_ge_b ? a_mant : b_mant;
   assign small_mant = a_ge_b ? b_mant : a_mant;

   // shifts past 27 leave only the sticky bit
   assign exp_diff = big_exp - small_exp;
   assign shift    = (exp_diff > 8'd27) ? 5'd27 : exp_diff[4:0];

   // bits shifted out land in the lower half
   assign shifted_wide = {small_mant, 3'b000, 27'b0} >> shift;
   assign sticky       = |shifted_wide[26:0];

   always_ff @(posedge clk) begin
      if (rst) begin
         s1_sign    <= 1'b0;
         s1_eff_sub <= 1'b0;
         s1_exp     <= '0;
         s1_big     <= '0;
         s1_small   <= '0;
      end else begin
         s1_sign    <= a_ge_b ? a[31] : b_sign;
         s1_eff_sub <= a[31] ^ b_sign;
         s1_exp     <= big_exp;
         s1_big     <= {big_mant, 3'b000};
         s1_small   <= {shifted_wide[53:28], shifted_wide[27] | sticky};
      end
   end

endmodule

// File: design/fp_frac_add.sv
`timescale 1ns/1ns
////////////////////////////////////////////////////////////////////////////
// expects s1_big to hold the larger magnitude
////////////////////////////////////////////////////////////////////////////
module fp_frac_add import fp_pkg::*; (
   input  logic      clk,
   input  logic      rst,
   input  logic      s1_sign,
   input  logic      s1_eff_sub,
   input  exp_t      s1_exp,
   input  ext_frac_t s1_big,
   input  ext_frac_t s1_small,
   output logic      s2_sign,
   output exp_t      s2_exp,
   output sum_t      s2_sum
);

   sum_t big_ext;
   sum_t small_ext;
   sum_t sum;

   // one spare bit on top for the carry
   assign big_ext   = {1'b0, s1_big};
   assign small_ext = {1'b0, s1_small};

   // difference stays non-negative since the operands are ordered
   assign sum = s1_eff_sub ? (big_ext - small_ext)
                           : (big_ext + small_ext);

   always_ff @(posedge clk) begin
      if (rst) begin
         s2_sign <= 1'b0;
         s2_exp  <= '0;
         s2_sum  <= '0;
      end else begin
         s2_sign <= s1_sign;
         s2_exp  <= s1_exp;
         s2_sum  <= sum;
      end
   end

   // a borrow here would mean stage 1 ordered the operands wrong
   sub_no_carry: assert property (
      @(posedge clk) disable iff (rst)
      s1_eff_sub |=> !s2_sum[27]
   );

endmodule

// File: fp_round/fp_lzc.sv
`timescale 1ns/1ns
////////////////////////////////////////////////////////////////////////////
// count is taken from bit 27 and is 0 when value is all zero
////////////////////////////////////////////////////////////////////////////
module fp_lzc import fp_pkg::*; (
   input  sum_t   value,
   output shamt_t count,
   output logic   all_zero
);

   // ascending scan so the highest set bit wins
   always_comb begin
      count = '0;
      for (int i = 0; i < 28; i++) begin
         if (value[i]) begin
            count = shamt_t'(27 - i);
         end
      end
   end

   assign all_zero = (value == '0);

endmodule

// File: fp_round/fp_round.sv
`timescale 1ns/1ns
////////////////////////////////////////////////////////////////////////////
// tiny results flush to signed zero and tininess is checked after rounding
////////////////////////////////////////////////////////////////////////////
module fp_round import fp_pkg::*; (
   input  logic  clk,
   input  logic  rst,
   input  logic  s2_sign,
   input  exp_t  s2_exp,
   input  sum_t  s2_sum,
   input  rm_t   s2_rm,
   output fp32_t round_result,
   output logic  round_ovf,
   output logic  round_unf,
   output logic  round_inexact
);

   logic              carry;
   shamt_t            lz;
   logic              sum_zero;
   shamt_t            lshift;
   ext_frac_t         norm;
   logic signed [9:0] exp_norm;
   logic signed [9:0] exp_final;
   mant_t             mant;
   logic              guard;
   logic              lost;
   logic              round_up;
   logic              to_inf;
   logic [24:0]       rounded;
   fp32_t             result_n;
   logic              ovf_n;
   logic              unf_n;
   logic              inexact_n;

   fp_lzc u_lzc (
      .value    (s2_sum),
      .count    (lz),
      .all_zero (sum_zero)
   );

   assign carry = s2_sum[27];

   // lz includes the carry position so the left shift is one less
   assign lshift = lz - 5'd1;

   // normalize so the hidden bit sits at bit 26
   always_comb begin
      if (carry) begin
         norm     = {s2_sum[27:2], |s2_sum[1:0]};
         exp_norm = $signed({2'b00, s2_exp}) + 10'sd1;
      end else begin
         norm     = s2_sum[26:0] << lshift;
         exp_norm = $signed({2'b00, s2_exp}) - $signed({5'b00000, lshift});
      end
   end

   assign mant  = norm[26:3];
   assign guard = norm[2];
   assign lost  = |norm[2:0];

   // increment decision per mode
   always_comb begin
      case (s2_rm)
         RM_RTZ:  round_up = 1'b0;
         RM_RDN:  round_up = s2_sign & lost;
         RM_RUP:  round_up = !s2_sign & lost;
         RM_RMM:  round_up = guard;
         default: round_up = guard & (|norm[1:0] | mant[0]);
      endcase
   end

   // which modes let an overflow reach infinity
   always_comb begin
      case (s2_rm)
         RM_RTZ:  to_inf = 1'b0;
         RM_RDN:  to_inf = s2_sign;
         RM_RUP:  to_inf = !s2_sign;
         default: to_inf = 1'b1;
      endcase
   end

   // a carry out of rounding leaves the fraction all zero
   assign rounded   = {1'b0, mant} + {24'b0, round_up};
   assign exp_final = exp_norm + $signed({9'b0, rounded[24]});

   always_comb begin
      result_n  = {s2_sign, exp_final[7:0], rounded[22:0]};
      ovf_n     = 1'b0;
      unf_n     = 1'b0;
      inexact_n = lost;
      if (sum_zero) begin
         // exact cancellation
         result_n  = {s2_rm == RM_RDN, 31'b0};
         inexact_n = 1'b0;
      end else if (exp_final >= 10'sd255) begin
         ovf_n     = 1'b1;
         inexact_n = 1'b1;
         if (to_inf) begin
            result_n = s2_sign ? NEG_INF : POS_INF;
         end else begin
            result_n = MAX_FINITE | {s2_sign, 31'b0};
         end
      end else if (exp_final <= 10'sd0) begin
         unf_n     = 1'b1;
         inexact_n = 1'b1;
         result_n  = {s2_sign, 31'b0};
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         round_result  <= '0;
         round_ovf     <= 1'b0;
         round_unf     <= 1'b0;
         round_inexact <= 1'b0;
      end else begin
         round_result  <= result_n;
         round_ovf     <= ovf_n;
         round_unf     <= unf_n;
         round_inexact <= inexact_n;
      end
   end

   // lzc count and shift together must bring the leading one to bit 26
   norm_hidden_bit: assert property (
      @(posedge clk) disable iff (rst)
      !sum_zero |-> norm[26]
   );

endmodule

// File: design/fp_addsub_ctrl.sv
`timescale 1ns/1ns
////////////////////////////////////////////////////////////////////////////
// fixed three cycle latency with no back-pressure
////////////////////////////////////////////////////////////////////////////
module fp_addsub_ctrl import fp_pkg::*; (
   input  logic  clk,
   input  logic  rst,
   input  logic  in_valid,
   input  fp32_t a,
   input  fp32_t b,
   input  logic  sub,
   input  rm_t   rm,
   input  fp32_t round_result,
   input  logic  round_ovf,
   input  logic  round_unf,
   input  logic  round_inexact,
   output rm_t   s2_rm,
   output logic  out_valid,
   output fp32_t result,
   output logic  ovf,
   output logic  unf,
   output logic  inexact,
   output logic  invalid
);

   logic       b_sign;
   logic       a_nan;
   logic       b_nan;
   logic       a_inf;
   logic       b_inf;
   logic       any_nan;
   logic       snan;
   logic       inf_clash;
   logic       special_n;
   logic       invalid_n;
   fp32_t      special_result_n;
   logic [2:0] valid_q;
   logic [2:0] special_q;
   logic [2:0] invalid_q;
   fp32_t      special_result_q [3];
   rm_t        rm_q [2];

   // effective sign of b after the subtract flip
   assign b_sign = b[31] ^ sub;

   assign a_nan = (&a[30:23]) & (|a[22:0]);
   assign b_nan = (&b[30:23]) & (|b[22:0]);
   assign a_inf = (&a[30:23]) & ~(|a[22:0]);
   assign b_inf = (&b[30:23]) & ~(|b[22:0]);

   assign any_nan = a_nan | b_nan;
   // signalling NaN has the quiet bit clear
   assign snan      = (a_nan & ~a[22]) | (b_nan & ~b[22]);
   assign inf_clash = a_inf & b_inf & (a[31] ^ b_sign);

   assign special_n = in_valid & (any_nan | a_inf | b_inf);
   assign invalid_n = in_valid & (any_nan ? snan : inf_clash);

   always_comb begin
      if (any_nan || inf_clash) begin
         special_result_n = QNAN;
      end else if (a_inf) begin
         special_result_n = a[31] ? NEG_INF : POS_INF;
      end else begin
         special_result_n = b_sign ? NEG_INF : POS_INF;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         valid_q   <= '0;
         special_q <= '0;
         invalid_q <= '0;
      end else begin
         valid_q   <= {valid_q[1:0], in_valid};
         special_q <= {special_q[1:0], special_n};
         invalid_q <= {invalid_q[1:0], invalid_n};
      end
   end

   // rm only needs to reach the rounding stage
   always_ff @(posedge clk) begin
      special_result_q[0] <= special_result_n;
      special_result_q[1] <= special_result_q[0];
      special_result_q[2] <= special_result_q[1];
      rm_q[0]             <= rm;
      rm_q[1]             <= rm_q[0];
   end

   assign s2_rm = rm_q[1];

   // special operands override the rounded datapath
   assign out_valid = valid_q[2];
   assign result    = special_q[2] ? special_result_q[2] : round_result;
   assign ovf       = round_ovf & ~special_q[2];
   assign unf       = round_unf & ~special_q[2];
   assign inexact   = round_inexact & ~special_q[2];
   assign invalid   = invalid_q[2];

   // any NaN leaving the adder is the canonical one
   canonical_nan: assert property (
      @(posedge clk) disable iff (rst)
      out_valid && (&result[30:23]) && (|result[22:0]) |-> result == QNAN
   );

endmodule

// File: design/fp_addsub_top.sv
`timescale 1ns/1ns
////////////////////////////////////////////////////////////////////////////
// results appear three cycles after in_valid and are not held
////////////////////////////////////////////////////////////////////////////
module fp_addsub_top import fp_pkg::*; (
   input  logic  clk,
   input  logic  rst,
   input  logic  in_valid,
   input  fp32_t a,
   input  fp32_t b,
   input  logic  sub,
   input  rm_t   rm,
   output logic  out_valid,
   output fp32_t result,
   output logic  ovf,
   output logic  unf,
   output logic  inexact,
   output logic  invalid
);

   logic      s1_sign;
   logic      s1_eff_sub;
   exp_t      s1_exp;
   ext_frac_t s1_big;
   ext_frac_t s1_small;
   logic      s2_sign;
   exp_t      s2_exp;
   sum_t      s2_sum;
   rm_t       s2_rm;
   fp32_t     round_result;
   logic      round_ovf;
   logic      round_unf;
   logic      round_inexact;

   fp_addsub_ctrl u_ctrl (
      .clk           (clk),
      .rst           (rst),
      .in_valid      (in_valid),
      .a             (a),
      .b             (b),
      .sub           (sub),
      .rm            (rm),
      .round_result  (round_result),
      .round_ovf     (round_ovf),
      .round_unf     (round_unf),
      .round_inexact (round_inexact),
      .s2_rm         (s2_rm),
      .out_valid     (out_valid),
      .result        (result),
      .ovf           (ovf),
      .unf           (unf),
      .inexact       (inexact),
      .invalid       (invalid)
   );

   // stage 1
   fp_align u_align (
      .clk        (clk),
      .rst        (rst),
      .a          (a),
      .b          (b),
      .sub        (sub),
      .s1_sign    (s1_sign),
      .s1_eff_sub (s1_eff_sub),
      .s1_exp     (s1_exp),
      .s1_big     (s1_big),
      .s1_small   (s1_small)
   );

   // stage 2
   fp_frac_add u_frac_add (
      .clk        (clk),
      .rst        (rst),
      .s1_sign    (s1_sign),
      .s1_eff_sub (s1_eff_sub),
      .s1_exp     (s1_exp),
      .s1_big     (s1_big),
      .s1_small   (s1_small),
      .s2_sign    (s2_sign),
      .s2_exp     (s2_exp),
      .s2_sum     (s2_sum)
   );

   // stage 3
   fp_round u_round (
      .clk           (clk),
      .rst           (rst),
      .s2_sign       (s2_sign),
      .s2_exp        (s2_exp),
      .s2_sum        (s2_sum),
      .s2_rm         (s2_rm),
      .round_result  (round_result),
      .round_ovf     (round_ovf),
      .round_unf     (round_unf),
      .round_inexact (round_inexact)
   );

endmodule

// File: tests/fp_model.svh
`ifndef FP_MODEL_SVH
`define FP_MODEL_SVH
////////////////////////////////////////////////////////////////////////////
// exact sum in a wide integer rounded once, subnormal inputs read as zero
////////////////////////////////////////////////////////////////////////////

// room for a 24 bit significand shifted across the whole exponent range
typedef logic [287:0] wide_t;

task automatic model_addsub(
   input  fp32_t op_a,
   input  fp32_t op_b,
   input  logic  op_sub,
   input  rm_t   op_rm,
   output fp32_t res,
   output logic  ovf_flag,
   output logic  unf_flag,
   output logic  inx_flag,
   output logic  inv_flag
);
   logic        sa;
   logic        sb;
   logic        sr;
   logic        a_nan;
   logic        b_nan;
   logic        a_inf;
   logic        b_inf;
   logic        guard;
   logic        sticky;
   logic        inc;
   logic        to_inf;
   int          ea;
   int          eb;
   int          e_lo;
   int          p;
   int          e_res;
   wide_t       ma;
   wide_t       mb;
   wide_t       sum;
   logic [24:0] m;

   sa       = op_a[31];
   sb       = op_b[31] ^ op_sub;
   a_nan    = (op_a[30:23] == 8'hff) && (op_a[22:0] != 23'h0);
   b_nan    = (op_b[30:23] == 8'hff) && (op_b[22:0] != 23'h0);
   a_inf    = (op_a[30:23] == 8'hff) && (op_a[22:0] == 23'h0);
   b_inf    = (op_b[30:23] == 8'hff) && (op_b[22:0] == 23'h0);
   res      = '0;
   ovf_flag = 1'b0;
   unf_flag = 1'b0;
   inx_flag = 1'b0;
   inv_flag = 1'b0;
   if (a_nan || b_nan) begin
      res      = 32'h7fc0_0000;
      inv_flag = (a_nan && !op_a[22]) || (b_nan && !op_b[22]);
   end else if (a_inf && b_inf && (sa != sb)) begin
      res      = 32'h7fc0_0000;
      inv_flag = 1'b1;
   end else if (a_inf || b_inf) begin
      res = {a_inf ? sa : sb, 8'hff, 23'h0};
   end else begin
      // operand value is m * 2^(e - 150)
      ea = int'(op_a[30:23]);
      eb = int'(op_b[30:23]);
      ma = (ea == 0) ? '0 : wide_t'({1'b1, op_a[22:0]});
      mb = (eb == 0) ? '0 : wide_t'({1'b1, op_b[22:0]});
      // a zero operand borrows the other exponent
      if (ea == 0) ea = eb;
      if (eb == 0) eb = ea;
      e_lo = (ea < eb) ? ea : eb;
      ma   = ma << (ea - e_lo);
      mb   = mb << (eb - e_lo);
      if (sa == sb) begin
         sum = ma + mb;
         sr  = sa;
      end else if (ma >= mb) begin
         sum = ma - mb;
         sr  = sa;
      end else begin
         sum = mb - ma;
         sr  = sb;
      end
      p = 0;
      for (int i = 0; i < 288; i++) begin
         if (sum[i]) p = i;
      end
      if (sum == '0) begin
         res = {op_rm == RM_RDN, 31'h0};
      end else begin
         if (p > 23) begin
            m      = {1'b0, 24'(sum >> (p - 23))};
            guard  = sum[p - 24];
            sticky = |(sum & ((wide_t'(1) << (p - 24)) - wide_t'(1)));
         end else begin
            m      = {1'b0, 24'(sum << (23 - p))};
            guard  = 1'b0;
            sticky = 1'b0;
         end
         e_res = p + e_lo - 23;
         case (op_rm)
            RM_RTZ:  inc = 1'b0;
            RM_RDN:  inc = sr & (guard | sticky);
            RM_RUP:  inc = !sr & (guard | sticky);
            RM_RMM:  inc = guard;
            default: inc = guard & (sticky | m[0]);
         endcase
         case (op_rm)
            RM_RTZ:  to_inf = 1'b0;
            RM_RDN:  to_inf = sr;
            RM_RUP:  to_inf = !sr;
            default: to_inf = 1'b1;
         endcase
         m = m + 25'(inc);
         // rounding carry moves the point by one
         if (m[24]) begin
            m     = m >> 1;
            e_res = e_res + 1;
         end
         inx_flag = guard | sticky;
         if (e_res >= 255) begin
            ovf_flag = 1'b1;
            inx_flag = 1'b1;
            res      = to_inf ? {sr, 8'hff, 23'h0} : {sr, 8'hfe, 23'h7f_ffff};
         end else if (e_res <= 0) begin
            unf_flag = 1'b1;
            inx_flag = 1'b1;
            res      = {sr, 31'h0};
         end else begin
            res = {sr, e_res[7:0], m[22:0]};
         end
      end
   end
endtask

`endif

// File: tests/fp_addsub_tb.sv
`timescale 1ns/1ns
////////////////////////////////////////////////////////////////////////////
// random stimulus from a fixed seed, each group runs in all five modes
////////////////////////////////////////////////////////////////////////////
module fp_addsub_tb import fp_pkg::*; ();

   localparam int RESET_CYCLES = 5;
   localparam int MODES        = 5;
   localparam int NUM_NORMAL   = 30;
   localparam int NUM_CANCEL   = 20;
   localparam int NUM_ZERO     = 4;
   localparam int NUM_OVF      = 10;
   localparam int NUM_UNF      = 10;
   localparam int NUM_SPECIAL  = 14;
   localparam int NUM_GAPPED   = 60;
   localparam int MAX_GAP      = 3;
   localparam int TOTAL_OPS    = MODES * (NUM_NORMAL + NUM_CANCEL + NUM_ZERO + NUM_OVF
                                          + NUM_UNF + NUM_SPECIAL) + NUM_GAPPED;
   localparam int CYCLE_LIMIT  = RESET_CYCLES + TOTAL_OPS + NUM_GAPPED * MAX_GAP + 20;

   // NaN, infinity and subnormal corner cases
   localparam fp32_t SPEC_A [NUM_SPECIAL] = '{
      32'h7fc00000, 32'h3f800000, 32'hffc00001, 32'h7f800000, 32'h7f800000, 32'hff800000,
      32'h7f800000, 32'h3f800000, 32'h00000123, 32'h3fc00000, 32'h00400000, 32'h80000000,
      32'hff800000, 32'h7f800000};
   localparam fp32_t SPEC_B [NUM_SPECIAL] = '{
      32'h3f800000, 32'h7f800001, 32'h7fa00000, 32'h7f800000, 32'hff800000, 32'hff800000,
      32'h40490fdb, 32'h7f800000, 32'h3f800000, 32'h807fffff, 32'h80000001, 32'h80000000,
      32'h7fc00000, 32'h00000005};
   localparam logic [NUM_SPECIAL-1:0] SPEC_SUB = 14'b00_0010_1100_1000;

   logic       clk;
   logic       rst;
   logic       in_valid;
   fp32_t      a;
   fp32_t      b;
   logic       sub;
   rm_t        rm;
   logic       out_valid;
   fp32_t      result;
   logic       ovf;
   logic       unf;
   logic       inexact;
   logic       invalid;

   integer     seed = 48;
   int         cycle_count = 0;
   string      name_q [$];
   fp32_t      res_q [$];
   logic [3:0] flag_q [$];
   string      want_name;
   fp32_t      want_res;
   logic [3:0] want_flags;

   `include "fp_model.svh"

   fp_addsub_top uut (
      .clk       (clk),
      .rst       (rst),
      .in_valid  (in_valid),
      .a         (a),
      .b         (b),
      .sub       (sub),
      .rm        (rm),
      .out_valid (out_valid),
      .result    (result),
      .ovf       (ovf),
      .unf       (unf),
      .inexact   (inexact),
      .invalid   (invalid)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   function automatic int rand_below(input int n);
      return int'($unsigned($random(seed)) % n);
   endfunction

   function automatic fp32_t make_normal(input int exp_lo, input int exp_hi);
      logic        sign;
      exp_t        e;
      logic [22:0] frac;
      sign = 1'(rand_below(2));
      e    = exp_t'(exp_lo + rand_below(exp_hi - exp_lo + 1));
      frac = 23'($random(seed));
      return {sign, e, frac};
   endfunction

   task automatic check_result(input string name, input fp32_t expected, input fp32_t actual);
      if (actual !== expected) begin
         $display("error %s result expected %h actual %h", name, expected, actual);
         $display("test failed");
         $fatal(1, "result mismatch");
      end
   endtask

   task automatic check_flags(input string name,
                              input logic e_ovf, input logic e_unf,
                              input logic e_inx, input logic e_inv,
                              input logic a_ovf, input logic a_unf,
                              input logic a_inx, input logic a_inv);
      if ({a_ovf, a_unf, a_inx, a_inv} !== {e_ovf, e_unf, e_inx, e_inv}) begin
         $display("error %s flags ovf/unf/inexact/invalid expected %b%b%b%b actual %b%b%b%b",
                  name, e_ovf, e_unf, e_inx, e_inv, a_ovf, a_unf, a_inx, a_inv);
         $display("test failed");
         $fatal(1, "flag mismatch");
      end
   endtask

   // one operation per call, in_valid stays high for the next call
   task automatic drive_op(input string group, input fp32_t op_a, input fp32_t op_b,
                           input logic op_sub, input rm_t op_rm);
      fp32_t e_res;
      logic  e_ovf;
      logic  e_unf;
      logic  e_inx;
      logic  e_inv;
      @(posedge clk);
      in_valid <= 1'b1;
      a        <= op_a;
      b        <= op_b;
      sub      <= op_sub;
      rm       <= op_rm;
      model_addsub(op_a, op_b, op_sub, op_rm, e_res, e_ovf, e_unf, e_inx, e_inv);
      name_q.push_back($sformatf("%s a=%h b=%h sub=%b rm=%0d", group, op_a, op_b, op_sub,
                                 op_rm));
      res_q.push_back(e_res);
      flag_q.push_back({e_ovf, e_unf, e_inx, e_inv});
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) begin
         @(posedge clk);
         in_valid <= 1'b0;
      end
   endtask

   // kind 0 normal, 1 cancel, 2 exact zero, 3 overflow, 4 underflow, 5 special
   task automatic make_pair(input int kind, input int idx,
                            output fp32_t op_a, output fp32_t op_b, output logic op_sub);
      op_sub = 1'(rand_below(2));
      op_a   = make_normal(97, 157);
      op_b   = make_normal(97, 157);
      case (kind)
         1: begin
            op_sub = 1'b1;
            op_b   = {op_a[31], op_a[30:23] - exp_t'(rand_below(2)),
                      op_a[22:0] ^ 23'(rand_below(256))};
         end
         2: begin
            op_sub = !idx[0];
            op_b   = {op_a[31] ^ idx[0], op_a[30:0]};
         end
         3: begin
            op_a = {op_a[31], 8'hfe, op_a[22:0]};
            op_b = {op_a[31] ^ op_sub, exp_t'(253 + rand_below(2)), op_b[22:0]};
         end
         4: begin
            op_a = {op_a[31], exp_t'(1 + rand_below(2)), op_a[22:0]};
            op_b = {~op_a[31] ^ op_sub, 8'h01, op_b[22:0]};
         end
         5: begin
            op_a   = SPEC_A[idx];
            op_b   = SPEC_B[idx];
            op_sub = SPEC_SUB[idx];
         end
         default: ;
      endcase
   endtask

   task automatic run_group(input string group, input int kind, input int pairs);
      fp32_t op_a;
      fp32_t op_b;
      logic  op_sub;
      for (int i = 0; i < pairs; i++) begin
         make_pair(kind, i, op_a, op_b, op_sub);
         for (int m = 0; m < MODES; m++) begin
            drive_op(group, op_a, op_b, op_sub, rm_t'(m));
         end
      end
   endtask

   // random gaps, rounding codes 5 to 7 included
   task automatic run_gapped(input int count);
      fp32_t op_a;
      fp32_t op_b;
      logic  op_sub;
      rm_t   op_rm;
      for (int i = 0; i < count; i++) begin
         op_a   = make_normal(97, 157);
         op_b   = make_normal(97, 157);
         op_sub = 1'(rand_below(2));
         op_rm  = rm_t'(rand_below(8));
         drive_op("gapped", op_a, op_b, op_sub, op_rm);
         idle_cycles(rand_below(MAX_GAP + 1));
      end
   endtask

   initial begin
      rst      = 1'b1;
      in_valid = 1'b0;
      a        = '0;
      b        = '0;
      sub      = 1'b0;
      rm       = '0;
      repeat (RESET_CYCLES) @(posedge clk);
      rst <= 1'b0;
      idle_cycles(4);
      run_group("normal", 0, NUM_NORMAL);
      run_group("cancel", 1, NUM_CANCEL);
      run_group("exact_zero", 2, NUM_ZERO);
      run_group("overflow", 3, NUM_OVF);
      run_group("underflow", 4, NUM_UNF);
      run_group("special", 5, NUM_SPECIAL);
      run_gapped(NUM_GAPPED);
      idle_cycles(1);
      while (res_q.size() != 0) @(posedge clk);
      // a stray out_valid here would still be caught
      repeat (5) @(posedge clk);
      $display("test passed");
      $finish;
   end

   // outputs are sampled mid cycle
   always @(negedge clk) begin
      if (!rst && out_valid) begin
         if (res_q.size() == 0) begin
            $display("out_valid was raised with no operation in flight");
            $display("test failed");
            $fatal(1, "unexpected output");
         end else begin
            want_name  = name_q.pop_front();
            want_res   = res_q.pop_front();
            want_flags = flag_q.pop_front();
            check_result(want_name, want_res, result);
            check_flags(want_name, want_flags[3], want_flags[2], want_flags[1],
                        want_flags[0], ovf, unf, inexact, invalid);
         end
      end
   end

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= CYCLE_LIMIT) begin
         $display("timeout after %0d cycles with %0d results outstanding", cycle_count,
                  res_q.size());
         $display("test failed");
         $fatal(1, "simulation timeout");
      end
   end

endmodule

// File: vlog.f
+incdir+tests
common/fp_pkg.sv
design/fp_align.sv
design/fp_frac_add.sv
fp_round/fp_lzc.sv
fp_round/fp_round.sv
design/fp_addsub_ctrl.sv
design/fp_addsub_top.sv
tests/fp_addsub_tb.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = fp_addsub_tb
FILELIST  = vlog.f

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

.PHONY: sim clean
